// File: include/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Address of the first fetch after reset
`define FETCH_RESET_VECTOR 32'h0000_0100

// Direct-mapped cache depth, must be a power of two
`define FETCH_ICACHE_LINES 16

// Word width of pc, bus and instruction
`define FETCH_XLEN 32

// Running tag attached to each record sent to decode
`define FETCH_TAG_WIDTH 8

`endif

// File: hdl/fetch_pkg.sv
`include "fetch_consts.svh"

package fetch_pkg;

	// Major opcode groups seen by the predecoder
	typedef enum logic [3:0] {
		OC_LUI,
		OC_AUIPC,
		OC_JAL,
		OC_JALR,
		OC_BRANCH,
		OC_LOAD,
		OC_STORE,
		OC_OP_IMM,
		OC_OP,
		OC_SYSTEM,
		OC_LOAD_FP,
		OC_STORE_FP,
		OC_OP_FP,
		OC_FMADD,
		OC_OTHER
	} opcode_class_t;

	// Fetch controller FSM
	typedef enum logic [1:0] {
		FS_REQUEST,
		FS_WAIT_CACHE,
		FS_WAIT_JUMP
	} fetch_state_t;

	// Record handed to decode
	// Register fields are {bank, index}, bank set for float registers
	typedef struct packed {
		logic [`FETCH_TAG_WIDTH-1:0] tag;
		logic [`FETCH_XLEN-1:0] pc;
		logic [`FETCH_XLEN-1:0] instruction;
		logic [5:0] rs1;
		logic [5:0] rs2;
		logic [5:0] rs3;
		logic [5:0] rd;
	} fetch_data_t;

endpackage

// File: hdl/fetch_icache_if.sv
`include "fetch_consts.svh"

interface fetch_icache_if;

	// Request side, one outstanding at a time
	logic req_valid;
	logic [`FETCH_XLEN-1:0] req_pc;
	logic req_ready;

	// Response side, single pulse per accepted request
	logic resp_valid;
	logic [`FETCH_XLEN-1:0] resp_rdata;

	modport ctrl (
		output req_valid,
		output req_pc,
		input req_ready,
		input resp_valid,
		input resp_rdata
	);

	modport cache (
		input req_valid,
		input req_pc,
		output req_ready,
		output resp_valid,
		output resp_rdata
	);

endinterface

// File: hdl/fetch_icache.sv
`include "fetch_consts.svh"

module fetch_icache (
	input logic i_clock,
	input logic i_reset,

	fetch_icache_if.cache icache,

	output logic o_bus_request,
	output logic [`FETCH_XLEN-1:0] o_bus_address,
	input logic i_bus_ready,
	input logic [`FETCH_XLEN-1:0] i_bus_rdata
);

	localparam int INDEX_BITS = $clog2(`FETCH_ICACHE_LINES);
	localparam int TAG_BITS = `FETCH_XLEN - INDEX_BITS - 2;

	typedef enum logic [1:0] {
		CS_IDLE,
		CS_REFILL,
		CS_RESPOND
	} cache_state_t;

	cache_state_t state;

	logic [`FETCH_ICACHE_LINES-1:0] line_valid;
	logic [TAG_BITS-1:0] line_tag [`FETCH_ICACHE_LINES];
	logic [`FETCH_XLEN-1:0] line_data [`FETCH_ICACHE_LINES];

	logic [`FETCH_XLEN-1:0] refill_address;
	logic [`FETCH_XLEN-1:0] rdata;

	logic [INDEX_BITS-1:0] req_index;
	logic [TAG_BITS-1:0] req_tag;
	logic [INDEX_BITS-1:0] refill_index;
	logic [TAG_BITS-1:0] refill_tag;
	logic req_accept;
	logic req_hit;

	// Word address split, byte offset bits are dropped
	assign req_index = icache.req_pc[2 +: INDEX_BITS];
	assign req_tag = icache.req_pc[`FETCH_XLEN-1 -: TAG_BITS];
	assign refill_index = refill_address[2 +: INDEX_BITS];
	assign refill_tag = refill_address[`FETCH_XLEN-1 -: TAG_BITS];

	assign req_accept = icache.req_valid && icache.req_ready;
	assign req_hit = line_valid[req_index] && (line_tag[req_index] == req_tag);

	assign icache.req_ready = (state == CS_IDLE);
	assign icache.resp_valid = (state == CS_RESPOND);
	assign icache.resp_rdata = rdata;

	// Address register holds steady for the whole bus read
	assign o_bus_request = (state == CS_REFILL);
	assign o_bus_address = refill_address;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= CS_IDLE;
			line_valid <= '0;
		end
		else begin
			case (state)
				CS_IDLE: begin
					if (req_accept) begin
						if (req_hit)
							state <= CS_RESPOND;
						else
							state <= CS_REFILL;
					end
				end

				CS_REFILL: begin
					if (i_bus_ready) begin
						line_valid[refill_index] <= 1'b1;
						state <= CS_RESPOND;
					end
				end

				// Single-cycle response pulse
				CS_RESPOND:
					state <= CS_IDLE;

				default:
					state <= CS_IDLE;
			endcase
		end
	end

	// Line storage and response word
	always_ff @(posedge i_clock) begin
		if (state == CS_IDLE && req_accept) begin
			refill_address <= icache.req_pc;
			rdata <= line_data[req_index];
		end
		if (state == CS_REFILL && i_bus_ready) begin
			line_tag[refill_index] <= refill_tag;
			line_data[refill_index] <= i_bus_rdata;
			rdata <= i_bus_rdata;
		end
	end

endmodule

// File: hdl/fetch_predecode.sv
module fetch_predecode (
	input logic [31:0] i_instruction,

	output fetch_pkg::opcode_class_t o_class,
	output logic [5:0] o_rs1,
	output logic [5:0] o_rs2,
	output logic [5:0] o_rs3,
	output logic [5:0] o_rd,
	output logic o_control_transfer
);

	logic [6:0] opcode;
	logic [2:0] funct3;

	logic have_rs1;
	logic have_rs2;
	logic have_rs3;
	logic have_rd;

	logic bank_rs1;
	logic bank_rs2;
	logic bank_rd;

	assign opcode = i_instruction[6:0];
	assign funct3 = i_instruction[14:12];

	always_comb begin
		case (opcode)
			7'b0110111: o_class = fetch_pkg::OC_LUI;
			7'b0010111: o_class = fetch_pkg::OC_AUIPC;
			7'b1101111: o_class = fetch_pkg::OC_JAL;
			7'b1100111: o_class = fetch_pkg::OC_JALR;
			7'b1100011: o_class = fetch_pkg::OC_BRANCH;
			7'b0000011: o_class = fetch_pkg::OC_LOAD;
			7'b0100011: o_class = fetch_pkg::OC_STORE;
			7'b0010011: o_class = fetch_pkg::OC_OP_IMM;
			7'b0110011: o_class = fetch_pkg::OC_OP;
			7'b1110011: o_class = fetch_pkg::OC_SYSTEM;
			7'b0000111: o_class = fetch_pkg::OC_LOAD_FP;
			7'b0100111: o_class = fetch_pkg::OC_STORE_FP;
			7'b1010011: o_class = fetch_pkg::OC_OP_FP;
			// fmadd, fmsub, fnmsub, fnmadd
			7'b1000011, 7'b1000111, 7'b1001011, 7'b1001111: o_class = fetch_pkg::OC_FMADD;
			default: o_class = fetch_pkg::OC_OTHER;
		endcase
	end

	// Register usage follows the encoding format of each class
	always_comb begin
		have_rs1 = 1'b0;
		have_rs2 = 1'b0;
		have_rs3 = 1'b0;
		have_rd = 1'b0;
		case (o_class)
			fetch_pkg::OC_LUI, fetch_pkg::OC_AUIPC, fetch_pkg::OC_JAL:
				have_rd = 1'b1;
			fetch_pkg::OC_JALR, fetch_pkg::OC_LOAD, fetch_pkg::OC_OP_IMM,
			fetch_pkg::OC_LOAD_FP, fetch_pkg::OC_SYSTEM: begin
				have_rs1 = 1'b1;
				have_rd = 1'b1;
			end
			fetch_pkg::OC_BRANCH, fetch_pkg::OC_STORE, fetch_pkg::OC_STORE_FP: begin
				have_rs1 = 1'b1;
				have_rs2 = 1'b1;
			end
			fetch_pkg::OC_OP, fetch_pkg::OC_OP_FP: begin
				have_rs1 = 1'b1;
				have_rs2 = 1'b1;
				have_rd = 1'b1;
			end
			fetch_pkg::OC_FMADD: begin
				have_rs1 = 1'b1;
				have_rs2 = 1'b1;
				have_rs3 = 1'b1;
				have_rd = 1'b1;
			end
			default: ;
		endcase
	end

	// Float bank selection, every OP-FP counts as float-to-float
	assign bank_rd = (o_class == fetch_pkg::OC_LOAD_FP) || (o_class == fetch_pkg::OC_OP_FP)
		|| (o_class == fetch_pkg::OC_FMADD);
	assign bank_rs1 = (o_class == fetch_pkg::OC_OP_FP) || (o_class == fetch_pkg::OC_FMADD);
	assign bank_rs2 = (o_class == fetch_pkg::OC_STORE_FP) || (o_class == fetch_pkg::OC_OP_FP)
		|| (o_class == fetch_pkg::OC_FMADD);

	assign o_rs1 = have_rs1 ? {bank_rs1, i_instruction[19:15]} : 6'd0;
	assign o_rs2 = have_rs2 ? {bank_rs2, i_instruction[24:20]} : 6'd0;
	assign o_rs3 = have_rs3 ? {1'b1, i_instruction[31:27]} : 6'd0;
	assign o_rd = have_rd ? {bank_rd, i_instruction[11:7]} : 6'd0;

	// ecall, mret and wfi all sit under funct3 zero
	assign o_control_transfer = (o_class == fetch_pkg::OC_JAL) || (o_class == fetch_pkg::OC_JALR)
		|| (o_class == fetch_pkg::OC_BRANCH)
		|| (o_class == fetch_pkg::OC_SYSTEM && funct3 == 3'b000);

endmodule

// File: hdl/fetch_control.sv
`include "fetch_consts.svh"

module fetch_control (
	input logic i_clock,
	input logic i_reset,

	fetch_icache_if.ctrl icache,

	input logic [5:0] i_rs1,
	input logic [5:0] i_rs2,
	input logic [5:0] i_rs3,
	input logic [5:0] i_rd,
	input logic i_control_transfer,

	input logic i_jump,
	input logic [`FETCH_XLEN-1:0] i_jump_pc,

	input logic i_irq_pending,
	input logic [`FETCH_XLEN-1:0] i_irq_pc,
	output logic o_irq_dispatched,
	output logic [`FETCH_XLEN-1:0] o_irq_epc,

	output logic o_valid,
	output fetch_pkg::fetch_data_t o_data,
	input logic i_decode_ready
);

	fetch_pkg::fetch_state_t state;
	logic [`FETCH_XLEN-1:0] pc;
	logic [`FETCH_TAG_WIDTH-1:0] tag_count;
	logic drop_pending;

	logic out_free;
	logic irq_take;
	logic resp_keep;

	// Output register empty now or emptied this cycle
	assign out_free = !o_valid || i_decode_ready;

	// Source still holds the level during the dispatch pulse
	assign irq_take = i_irq_pending && !o_irq_dispatched
		&& (state != fetch_pkg::FS_WAIT_JUMP);

	assign resp_keep = icache.resp_valid && (state == fetch_pkg::FS_WAIT_CACHE) && !irq_take;

	assign icache.req_valid = (state == fetch_pkg::FS_REQUEST) && out_free && !drop_pending
		&& !irq_take;
	assign icache.req_pc = pc;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= fetch_pkg::FS_REQUEST;
			pc <= `FETCH_RESET_VECTOR;
			tag_count <= '0;
			o_valid <= 1'b0;
			o_irq_dispatched <= 1'b0;
		end
		else begin
			o_irq_dispatched <= irq_take;

			if (irq_take) begin
				pc <= i_irq_pc;
				state <= fetch_pkg::FS_REQUEST;
			end
			else begin
				case (state)
					fetch_pkg::FS_REQUEST: begin
						if (icache.req_valid && icache.req_ready)
							state <= fetch_pkg::FS_WAIT_CACHE;
					end

					fetch_pkg::FS_WAIT_CACHE: begin
						if (icache.resp_valid) begin
							// Park on the same pc until later stages redirect
							if (i_control_transfer) begin
								state <= fetch_pkg::FS_WAIT_JUMP;
							end
							else begin
								pc <= pc + `FETCH_XLEN'd4;
								state <= fetch_pkg::FS_REQUEST;
							end
						end
					end

					fetch_pkg::FS_WAIT_JUMP: begin
						if (i_jump) begin
							pc <= i_jump_pc;
							state <= fetch_pkg::FS_REQUEST;
						end
					end

					default:
						state <= fetch_pkg::FS_REQUEST;
				endcase
			end

			if (resp_keep) begin
				o_valid <= 1'b1;
				tag_count <= tag_count + 1'b1;
			end
			else if (i_decode_ready) begin
				o_valid <= 1'b0;
			end
		end
	end

	// Response still in the cache when the interrupt hit
	always_ff @(posedge i_clock) begin
		if (i_reset)
			drop_pending <= 1'b0;
		else if (icache.resp_valid)
			drop_pending <= 1'b0;
		else if (irq_take && state == fetch_pkg::FS_WAIT_CACHE)
			drop_pending <= 1'b1;
	end

	always_ff @(posedge i_clock) begin
		if (irq_take)
			o_irq_epc <= pc;
		if (resp_keep) begin
			o_data.tag <= tag_count + 1'b1;
			o_data.pc <= pc;
			o_data.instruction <= icache.resp_rdata;
			o_data.rs1 <= i_rs1;
			o_data.rs2 <= i_rs2;
			o_data.rs3 <= i_rs3;
			o_data.rd <= i_rd;
		end
	end

endmodule

// File: hdl/fetch_top.sv
`include "fetch_consts.svh"

module fetch_top (
	input logic i_clock,
	input logic i_reset,

	input logic i_jump,
	input logic [`FETCH_XLEN-1:0] i_jump_pc,

	input logic i_irq_pending,
	input logic [`FETCH_XLEN-1:0] i_irq_pc,
	output logic o_irq_dispatched,
	output logic [`FETCH_XLEN-1:0] o_irq_epc,

	output logic o_bus_request,
	output logic [`FETCH_XLEN-1:0] o_bus_address,
	input logic i_bus_ready,
	input logic [`FETCH_XLEN-1:0] i_bus_rdata,

	output logic o_valid,
	output fetch_pkg::fetch_data_t o_data,
	input logic i_decode_ready
);

	fetch_icache_if icache_bus();

	logic [5:0] predecode_rs1;
	logic [5:0] predecode_rs2;
	logic [5:0] predecode_rs3;
	logic [5:0] predecode_rd;
	logic predecode_control_transfer;

	fetch_icache icache_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.icache(icache_bus.cache),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

	// Register indices come straight off the cache response word
	fetch_predecode predecode_i (
		.i_instruction(icache_bus.resp_rdata),
		.o_class(),
		.o_rs1(predecode_rs1),
		.o_rs2(predecode_rs2),
		.o_rs3(predecode_rs3),
		.o_rd(predecode_rd),
		.o_control_transfer(predecode_control_transfer)
	);

	fetch_control control_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.icache(icache_bus.ctrl),
		.i_rs1(predecode_rs1),
		.i_rs2(predecode_rs2),
		.i_rs3(predecode_rs3),
		.i_rd(predecode_rd),
		.i_control_transfer(predecode_control_transfer),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.o_valid(o_valid),
		.o_data(o_data),
		.i_decode_ready(i_decode_ready)
	);

endmodule

// File: verif/fetch_clock_gen.sv
module fetch_clock_gen (
	output logic o_clock,
	output logic o_reset
);

	initial begin
		o_clock = 1'b0;
		forever #50 o_clock = ~o_clock;
	end

	// Reset covers the first four rising edges, released on a falling edge
	initial begin
		o_reset = 1'b1;
		repeat (4) @(posedge o_clock);
		@(negedge o_clock);
		o_reset = 1'b0;
	end

endmodule

// File: verif/fetch_assertions.sv
`include "fetch_consts.svh"

module fetch_assertions (
	input logic i_clock,
	input logic i_reset,
	input logic i_bus_request,
	input logic [`FETCH_XLEN-1:0] i_bus_address,
	input logic i_bus_ready,
	input logic i_valid,
	input fetch_pkg::fetch_data_t i_data,
	input logic i_decode_ready,
	input logic i_irq_dispatched,
	input logic i_req_valid,
	input logic i_req_ready,
	input logic i_resp_valid
);

	logic outstanding;
	logic accept;

	assign accept = i_req_valid && i_req_ready;

	// One cache request in flight between acceptance and its response
	always_ff @(posedge i_clock) begin
		if (i_reset)
			outstanding <= 1'b0;
		else if (accept)
			outstanding <= 1'b1;
		else if (i_resp_valid)
			outstanding <= 1'b0;
	end

	bus_hold: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_bus_request && !i_bus_ready) |=> (i_bus_request && $stable(i_bus_address)))
		else $error("bus address changed while the read was waiting");

	data_hold: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_valid && !i_decode_ready) |=> (i_valid && $stable(i_data)))
		else $error("decode record changed under back-pressure");

	irq_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
		i_irq_dispatched |=> !i_irq_dispatched)
		else $error("interrupt dispatch lasted more than one cycle");

	single_request: assert property (@(posedge i_clock) disable iff (i_reset)
		accept |-> !outstanding)
		else $error("cache accepted a second request before its response");

	response_owed: assert property (@(posedge i_clock) disable iff (i_reset)
		i_resp_valid |-> outstanding)
		else $error("cache responded with no request outstanding");

endmodule

bind fetch_top fetch_assertions assertions_i (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_bus_request(o_bus_request),
	.i_bus_address(o_bus_address),
	.i_bus_ready(i_bus_ready),
	.i_valid(o_valid),
	.i_data(o_data),
	.i_decode_ready(i_decode_ready),
	.i_irq_dispatched(o_irq_dispatched),
	.i_req_valid(icache_bus.req_valid),
	.i_req_ready(icache_bus.req_ready),
	.i_resp_valid(icache_bus.resp_valid)
);

// File: verif/fetch_tb.sv
`include "fetch_consts.svh"

module fetch_tb;

	localparam int RANDOM_RECORDS = 300;
	localparam int LOOP_PASSES = 8;
	localparam int PLANNED_RECORDS = RANDOM_RECORDS + `FETCH_ICACHE_LINES * (LOOP_PASSES + 1);
	localparam logic [31:0] LOOP_BASE = 32'h0002_0000;

	logic clock;
	logic reset;
	logic jump;
	logic [31:0] jump_pc;
	logic irq_pending;
	logic [31:0] irq_pc;
	logic irq_dispatched;
	logic [31:0] irq_epc;
	logic bus_request;
	logic [31:0] bus_address;
	logic bus_ready;
	logic [31:0] bus_rdata;
	logic valid;
	fetch_pkg::fetch_data_t data;
	logic decode_ready;

	int mismatches;
	int failures;
	int records;
	int transfers;
	int irqs_raised;
	int irqs_dispatched;
	int unsigned seed_draw;

	// Reference model state
	logic [31:0] exp_pc;
	logic [`FETCH_TAG_WIDTH-1:0] exp_tag;
	logic [`FETCH_TAG_WIDTH-1:0] last_tag;
	logic have_record;
	logic last_transferred;
	logic waiting_jump;
	int jump_delay;
	logic bus_busy;
	int bus_wait;
	logic loop_phase;
	int loop_jumps;
	logic [31:0] loop_start;
	logic bus_seen_in_loop;
	logic done;

	fetch_clock_gen clock_gen_i (
		.o_clock(clock),
		.o_reset(reset)
	);

	fetch_top dut_i (
		.i_clock(clock),
		.i_reset(reset),
		.i_jump(jump),
		.i_jump_pc(jump_pc),
		.i_irq_pending(irq_pending),
		.i_irq_pc(irq_pc),
		.o_irq_dispatched(irq_dispatched),
		.o_irq_epc(irq_epc),
		.o_bus_request(bus_request),
		.o_bus_address(bus_address),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata),
		.o_valid(valid),
		.o_data(data),
		.i_decode_ready(decode_ready)
	);

	function automatic logic [31:0] hash_word(input logic [31:0] address);
		logic [31:0] x;
		x = address ^ 32'h5bd1_e995;
		x = x * 32'h9e37_79b1;
		x = x ^ (x >> 15);
		x = x * 32'h85eb_ca6b;
		x = x ^ (x >> 13);
		return x;
	endfunction

	// Memory contents as a fixed function of the word address
	function automatic logic [31:0] memory_word(input logic [31:0] address);
		logic [31:0] h;
		logic [6:0] opcode;
		logic [2:0] funct3;
		h = hash_word(address);
		funct3 = h[14:12];
		if (h[2:0] == 3'd0) begin
			case (h[5:3])
				3'd0, 3'd1: opcode = 7'b1101111;
				3'd2: begin
					opcode = 7'b1100111;
					funct3 = 3'b000;
				end
				3'd6: return h[6] ? 32'h3020_0073 : 32'h0000_0073;
				3'd7: return 32'h1050_0073;
				default: opcode = 7'b1100011;
			endcase
		end
		else begin
			case (h[6:3])
				4'd0: opcode = 7'b0110111;
				4'd1: opcode = 7'b0010111;
				4'd2: opcode = 7'b0000011;
				4'd3: opcode = 7'b0100011;
				4'd4: opcode = 7'b0010011;
				4'd5: opcode = 7'b0110011;
				4'd6: begin
					// CSR access with a nonzero funct3
					opcode = 7'b1110011;
					if (funct3 == 3'b000)
						funct3 = 3'b010;
				end
				4'd7: opcode = 7'b0000111;
				4'd8: opcode = 7'b0100111;
				4'd9, 4'd10: opcode = 7'b1010011;
				4'd11: opcode = 7'b1000011;
				4'd12: opcode = 7'b1000111;
				4'd13: opcode = 7'b1001011;
				4'd14: opcode = 7'b1001111;
				default: opcode = 7'b0001111;
			endcase
		end
		return {h[31:15], funct3, h[11:7], opcode};
	endfunction

	function automatic logic is_control_transfer(input logic [31:0] word);
		logic [6:0] op;
		op = word[6:0];
		return op == 7'b1101111 || op == 7'b1100111 || op == 7'b1100011
			|| (op == 7'b1110011 && word[14:12] == 3'b000);
	endfunction

	// Expected {rs1, rs2, rs3, rd} per opcode with the bank bit on top of each field
	function automatic logic [23:0] expected_regs(input logic [31:0] w);
		logic [5:0] rs1;
		logic [5:0] rs2;
		logic [5:0] rs3;
		logic [5:0] rd;
		rs1 = 6'd0;
		rs2 = 6'd0;
		rs3 = 6'd0;
		rd = 6'd0;
		case (w[6:0])
			7'b0110111, 7'b0010111, 7'b1101111:
				rd = {1'b0, w[11:7]};
			7'b1100111, 7'b0000011, 7'b0010011, 7'b1110011: begin
				rs1 = {1'b0, w[19:15]};
				rd = {1'b0, w[11:7]};
			end
			7'b0000111: begin
				rs1 = {1'b0, w[19:15]};
				rd = {1'b1, w[11:7]};
			end
			7'b1100011, 7'b0100011: begin
				rs1 = {1'b0, w[19:15]};
				rs2 = {1'b0, w[24:20]};
			end
			7'b0100111: begin
				rs1 = {1'b0, w[19:15]};
				rs2 = {1'b1, w[24:20]};
			end
			7'b0110011: begin
				rs1 = {1'b0, w[19:15]};
				rs2 = {1'b0, w[24:20]};
				rd = {1'b0, w[11:7]};
			end
			7'b1010011: begin
				rs1 = {1'b1, w[19:15]};
				rs2 = {1'b1, w[24:20]};
				rd = {1'b1, w[11:7]};
			end
			7'b1000011, 7'b1000111, 7'b1001011, 7'b1001111: begin
				rs1 = {1'b1, w[19:15]};
				rs2 = {1'b1, w[24:20]};
				rs3 = {1'b1, w[31:27]};
				rd = {1'b1, w[11:7]};
			end
			default: ;
		endcase
		return {rs1, rs2, rs3, rd};
	endfunction

	// Start of a straight run that ends on a control transfer within one cache's worth
	function automatic logic [31:0] find_loop_start();
		logic [31:0] address;
		int steps;
		address = LOOP_BASE;
		steps = 0;
		while (!is_control_transfer(memory_word(address)) && steps < 256) begin
			address = address + 4;
			steps++;
		end
		if (address - LOOP_BASE > 4 * (`FETCH_ICACHE_LINES - 1))
			return address - 4 * (`FETCH_ICACHE_LINES - 1);
		return LOOP_BASE;
	endfunction

	function automatic logic [31:0] random_target();
		logic [31:0] r;
		r = $urandom;
		return {14'd0, r[15:0], 2'b00};
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			mismatches++;
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic note_failure(input string what);
		failures++;
		$display("ERROR at %0t: %s", $time, what);
	endtask

	task automatic handle_record();
		logic [31:0] word;
		if (!have_record || data.tag != last_tag) begin
			if (have_record && !last_transferred)
				note_failure("a record was replaced before decode took it");
			if (waiting_jump)
				note_failure("a record was delivered while fetch should wait for a jump");
			have_record = 1'b1;
			last_tag = data.tag;
			last_transferred = 1'b0;
			records++;
			exp_tag = exp_tag + 1'b1;
			word = memory_word(exp_pc);
			check_value(data.tag, exp_tag, "tag");
			check_value(data.pc, exp_pc, "pc");
			check_value(data.instruction, word, "instruction");
			check_value({data.rs1, data.rs2, data.rs3, data.rd}, expected_regs(word),
				"register fields");
			if (is_control_transfer(word)) begin
				waiting_jump = 1'b1;
				jump_delay = $urandom_range(1, 6);
				if (loop_phase && loop_jumps == LOOP_PASSES + 1)
					done = 1'b1;
			end
			else begin
				exp_pc = exp_pc + 4;
			end
		end
		else if (last_transferred) begin
			note_failure("a record was delivered twice");
		end
	endtask

	task automatic drive_decode();
		decode_ready = ($urandom_range(0, 9) < 7);
		if (valid && decode_ready) begin
			last_transferred = 1'b1;
			transfers++;
		end
	endtask

	task automatic drive_irq();
		if (irq_dispatched) begin
			if (!irq_pending)
				note_failure("interrupt dispatched with none pending");
			if (waiting_jump)
				note_failure("interrupt taken while fetch waits for a jump");
			check_value(irq_epc, exp_pc, "interrupt return pc");
			exp_pc = irq_pc;
			irq_pending = 1'b0;
			irqs_dispatched++;
		end
		else if (!irq_pending && records < RANDOM_RECORDS && $urandom_range(0, 39) == 0) begin
			irq_pending = 1'b1;
			irq_pc = random_target();
			irqs_raised++;
		end
	endtask

	task automatic drive_jump();
		logic [31:0] target;
		jump = 1'b0;
		if (waiting_jump && !done) begin
			if (jump_delay > 0) begin
				jump_delay--;
			end
			else begin
				if (!loop_phase && records >= RANDOM_RECORDS && !irq_pending) begin
					loop_phase = 1'b1;
					loop_start = find_loop_start();
				end
				if (loop_phase) begin
					target = loop_start;
					loop_jumps++;
				end
				else begin
					target = random_target();
				end
				jump = 1'b1;
				jump_pc = target;
				exp_pc = target;
				waiting_jump = 1'b0;
			end
		end
		else if (!waiting_jump && $urandom_range(0, 31) == 0) begin
			// Stray redirect that fetch must ignore while busy
			jump = 1'b1;
			jump_pc = random_target();
		end
	endtask

	task automatic drive_bus();
		if (loop_jumps >= 2 && bus_request && !bus_seen_in_loop) begin
			note_failure("bus read started while looping inside cached code");
			bus_seen_in_loop = 1'b1;
		end
		bus_rdata = $urandom;
		bus_ready = 1'b0;
		if (bus_request) begin
			if (!bus_busy) begin
				// A refill always reads the pc that fetch has not yet delivered
				check_value(bus_address, exp_pc, "bus read address");
				bus_busy = 1'b1;
				bus_wait = $urandom_range(0, 5);
			end
			if (bus_wait == 0) begin
				bus_ready = 1'b1;
				bus_rdata = memory_word(bus_address);
				bus_busy = 1'b0;
			end
			else begin
				bus_wait--;
			end
		end
	endtask

	initial begin
		jump = 1'b0;
		jump_pc = '0;
		irq_pending = 1'b0;
		irq_pc = '0;
		bus_ready = 1'b0;
		bus_rdata = '0;
		decode_ready = 1'b0;
		mismatches = 0;
		failures = 0;
		records = 0;
		transfers = 0;
		irqs_raised = 0;
		irqs_dispatched = 0;
		exp_pc = `FETCH_RESET_VECTOR;
		exp_tag = '0;
		last_tag = '0;
		have_record = 1'b0;
		last_transferred = 1'b0;
		waiting_jump = 1'b0;
		jump_delay = 0;
		bus_busy = 1'b0;
		bus_wait = 0;
		loop_phase = 1'b0;
		loop_jumps = 0;
		loop_start = LOOP_BASE;
		bus_seen_in_loop = 1'b0;
		done = 1'b0;
		seed_draw = $urandom(32'hc96c);

		wait (!reset);
		while (!(done && last_transferred)) begin
			@(negedge clock);
			if (valid)
				handle_record();
			drive_decode();
			drive_irq();
			drive_jump();
			drive_bus();
		end

		check_value(irqs_dispatched, irqs_raised, "interrupts dispatched");
		check_value(transfers, records, "records taken by decode");
		$display("records %0d, interrupts %0d, mismatches %0d, other errors %0d",
			records, irqs_dispatched, mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// Watchdog sized from the planned record count
	initial begin
		#(PLANNED_RECORDS * 20 * 100);
		$display("Timeout: fetch stopped delivering before the test finished");
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: flist.f
+incdir+include
hdl/fetch_pkg.sv
hdl/fetch_icache_if.sv
hdl/fetch_icache.sv
hdl/fetch_predecode.sv
hdl/fetch_control.sv
hdl/fetch_top.sv
verif/fetch_clock_gen.sv
verif/fetch_assertions.sv
verif/fetch_tb.sv
